// ==== source/core_pkg.sv ====
package core_pkg;

    localparam int XLEN = 64;
    localparam int PC_STEP = 4;          // fixed 32-bit instructions

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [4:0]      reg_addr_t;

    // major opcodes kept in this slice
    typedef enum logic [6:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b                       // lui
    } alu_op_e;

    typedef enum logic [2:0] {
        br_none,
        br_eq,
        br_ne,
        br_lt,
        br_ge,
        br_ltu,
        br_geu
    } br_op_e;

    typedef enum logic {opa_rs1, opa_pc}  opa_sel_e;
    typedef enum logic {opb_rs2, opb_imm} opb_sel_e;

    typedef struct packed {
        logic        valid;
        xlen_t       pc;
        logic [31:0] instr;
    } fetch_pkt_t;

    // all zero is a bubble
    typedef struct packed {
        logic      valid;
        xlen_t     pc;
        xlen_t     imm;
        xlen_t     rs1_val;
        xlen_t     rs2_val;
        reg_addr_t rd;
        logic      wen;
        alu_op_e   alu_op;
        opa_sel_e  opa_sel;
        opb_sel_e  opb_sel;
        br_op_e    br_op;
        logic      jal;
        logic      jalr;
    } id_ex_pkt_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        logic      wen;
        xlen_t     value;
    } ex_result_t;

endpackage

// ==== source/stage_reg.sv ====
module stage_reg #(
    parameter type      payload_t = logic,
    parameter payload_t RESET_VAL = '0
) (
    input  logic     clk,
    input  logic     rst_i,
    input  logic     flush_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // flush and reset both insert the bubble value
    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            q_o <= RESET_VAL;
        end else begin
            q_o <= d_i;
        end
    end

endmodule

// ==== source/inst_decoder.sv ====
module inst_decoder import core_pkg::*; (
    input  fetch_pkt_t fetch_i,
    input  xlen_t      rs1_val_i,
    input  xlen_t      rs2_val_i,
    output reg_addr_t  rs1_addr_o,
    output reg_addr_t  rs2_addr_o,
    output id_ex_pkt_t pkt_o
);

    logic [31:0] instr;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    reg_addr_t   rd;
    xlen_t       imm_i;
    xlen_t       imm_b;
    xlen_t       imm_u;
    xlen_t       imm_j;
    id_ex_pkt_t  pkt;
    logic        known;

    assign instr  = fetch_i.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];

    assign rs1_addr_o = instr[19:15];
    assign rs2_addr_o = instr[24:20];

    assign imm_i = {{52{instr[31]}}, instr[31:20]};
    assign imm_b = {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};
    assign imm_j = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // shared by op and op-imm, alt picks sub/sra
    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000: begin
                if (alt) op = alu_sub;
                else     op = alu_add;
            end
            3'b001: op = alu_sll;
            3'b010: op = alu_slt;
            3'b011: op = alu_sltu;
            3'b100: op = alu_xor;
            3'b101: begin
                if (alt) op = alu_sra;
                else     op = alu_srl;
            end
            3'b110: op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    always_comb begin
        pkt         = '0;
        known       = 1'b1;
        pkt.valid   = 1'b1;
        pkt.pc      = fetch_i.pc;
        pkt.rs1_val = rs1_val_i;
        pkt.rs2_val = rs2_val_i;
        pkt.rd      = rd;
        case (opcode)
            opc_op: begin
                pkt.alu_op = alu_sel(funct3, funct7[5]);
                pkt.wen    = 1'b1;
                if (funct7 != 7'b0000000 &&
                    !(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
                    known = 1'b0;                    // mul/div and friends
                end
            end
            opc_op_imm: begin
                pkt.alu_op  = alu_sel(funct3, (funct3 == 3'b101) && instr[30]);
                pkt.opb_sel = opb_imm;
                pkt.imm     = imm_i;
                pkt.wen     = 1'b1;
                if (funct3 == 3'b001 && instr[31:26] != 6'b000000) begin
                    known = 1'b0;
                end
                if (funct3 == 3'b101 && (instr[31:26] & 6'b101111) != 6'b000000) begin
                    known = 1'b0;
                end
            end
            opc_lui: begin
                pkt.alu_op  = alu_pass_b;
                pkt.opb_sel = opb_imm;
                pkt.imm     = imm_u;
                pkt.wen     = 1'b1;
            end
            opc_auipc: begin
                pkt.alu_op  = alu_add;
                pkt.opa_sel = opa_pc;
                pkt.opb_sel = opb_imm;
                pkt.imm     = imm_u;
                pkt.wen     = 1'b1;
            end
            opc_jal: begin
                pkt.jal = 1'b1;
                pkt.imm = imm_j;
                pkt.wen = 1'b1;
            end
            opc_jalr: begin
                pkt.jalr = 1'b1;
                pkt.imm  = imm_i;
                pkt.wen  = 1'b1;
                known    = (funct3 == 3'b000);
            end
            opc_branch: begin
                pkt.imm = imm_b;
                case (funct3)
                    3'b000:  pkt.br_op = br_eq;
                    3'b001:  pkt.br_op = br_ne;
                    3'b100:  pkt.br_op = br_lt;
                    3'b101:  pkt.br_op = br_ge;
                    3'b110:  pkt.br_op = br_ltu;
                    3'b111:  pkt.br_op = br_geu;
                    default: known = 1'b0;
                endcase
            end
            default: known = 1'b0;
        endcase
        pkt.wen = pkt.wen && (rd != 5'd0);           // x0 never written
    end

    assign pkt_o = (fetch_i.valid && known) ? pkt : '0;

endmodule

// ==== source/reg_file.sv ====
module reg_file import core_pkg::*; (
    input  logic       clk,
    input  logic       rst_i,
    input  reg_addr_t  rs1_addr_i,
    input  reg_addr_t  rs2_addr_i,
    output xlen_t      rs1_val_o,
    output xlen_t      rs2_val_o,
    input  ex_result_t wb_i
);

    xlen_t regs [32];
    logic  wr_en;

    assign wr_en = wb_i.valid && wb_i.wen && (wb_i.rd != 5'd0);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_i.rd] <= wb_i.value;
        end
    end

    // x0 reads zero, then same-cycle write wins
    function automatic xlen_t read_port(input reg_addr_t addr, input logic we,
                                        input reg_addr_t waddr, input xlen_t wdata,
                                        input xlen_t stored);
        xlen_t val;
        if (addr == 5'd0)                    val = '0;
        else if (we && addr == waddr)        val = wdata;
        else                                 val = stored;
        return val;
    endfunction

    assign rs1_val_o = read_port(rs1_addr_i, wr_en, wb_i.rd, wb_i.value, regs[rs1_addr_i]);
    assign rs2_val_o = read_port(rs2_addr_i, wr_en, wb_i.rd, wb_i.value, regs[rs2_addr_i]);

endmodule

// ==== source/exec_unit.sv ====
module exec_unit import core_pkg::*; (
    input  id_ex_pkt_t pkt_i,
    output ex_result_t result_o,
    output logic       redirect_o,
    output xlen_t      target_o
);

    xlen_t      op_a;
    xlen_t      op_b;
    xlen_t      alu_out;
    xlen_t      link_pc;
    xlen_t      jalr_sum;
    logic [5:0] shamt;
    logic       taken;

    assign op_a  = (pkt_i.opa_sel == opa_pc)  ? pkt_i.pc  : pkt_i.rs1_val;
    assign op_b  = (pkt_i.opb_sel == opb_imm) ? pkt_i.imm : pkt_i.rs2_val;
    assign shamt = op_b[5:0];                                // rv64 shift range

    always_comb begin
        case (pkt_i.alu_op)
            alu_add:    alu_out = op_a + op_b;
            alu_sub:    alu_out = op_a - op_b;
            alu_sll:    alu_out = op_a << shamt;
            alu_slt:    alu_out = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sltu:   alu_out = {{(XLEN-1){1'b0}}, op_a < op_b};
            alu_xor:    alu_out = op_a ^ op_b;
            alu_srl:    alu_out = op_a >> shamt;
            alu_sra:    alu_out = xlen_t'($signed(op_a) >>> shamt);
            alu_or:     alu_out = op_a | op_b;
            alu_and:    alu_out = op_a & op_b;
            alu_pass_b: alu_out = op_b;
            default:    alu_out = '0;
        endcase
    end

    // compare raw register values, not the muxed operands
    always_comb begin
        case (pkt_i.br_op)
            br_eq:   taken = (pkt_i.rs1_val == pkt_i.rs2_val);
            br_ne:   taken = (pkt_i.rs1_val != pkt_i.rs2_val);
            br_lt:   taken = ($signed(pkt_i.rs1_val) < $signed(pkt_i.rs2_val));
            br_ge:   taken = ($signed(pkt_i.rs1_val) >= $signed(pkt_i.rs2_val));
            br_ltu:  taken = (pkt_i.rs1_val < pkt_i.rs2_val);
            br_geu:  taken = (pkt_i.rs1_val >= pkt_i.rs2_val);
            default: taken = 1'b0;
        endcase
    end

    assign link_pc  = pkt_i.pc + xlen_t'(PC_STEP);
    assign jalr_sum = pkt_i.rs1_val + pkt_i.imm;

    assign redirect_o = pkt_i.valid && (taken || pkt_i.jal || pkt_i.jalr);
    assign target_o   = pkt_i.jalr ? {jalr_sum[XLEN-1:1], 1'b0}     // lsb dropped
                                   : pkt_i.pc + pkt_i.imm;

    always_comb begin
        result_o.valid = pkt_i.valid;
        result_o.rd    = pkt_i.rd;
        result_o.wen   = pkt_i.wen && (pkt_i.br_op == br_none);    // branches never write
        if (pkt_i.jal || pkt_i.jalr) begin
            result_o.value = link_pc;
        end else begin
            result_o.value = alu_out;
        end
    end

endmodule

// ==== source/id_ex_core.sv ====
module id_ex_core import core_pkg::*; #(
    parameter xlen_t RESET_PC = '0
) (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        valid_i,
    input  xlen_t       pc_i,
    input  logic [31:0] instr_i,
    output ex_result_t  result_o,
    output logic        redirect_o,
    output xlen_t       target_o
);

    localparam fetch_pkt_t FETCH_RESET = '{valid: 1'b0, pc: RESET_PC, instr: 32'h0};

    fetch_pkt_t fetch_in;
    fetch_pkt_t fetch_q;
    id_ex_pkt_t dec_pkt;
    id_ex_pkt_t ex_pkt;
    reg_addr_t  rs1_addr;
    reg_addr_t  rs2_addr;
    xlen_t      rs1_val;
    xlen_t      rs2_val;

    assign fetch_in = '{valid: valid_i, pc: pc_i, instr: instr_i};

    stage_reg #(
        .payload_t (fetch_pkt_t),
        .RESET_VAL (FETCH_RESET)
    ) u_if_id (
        .clk     (clk),
        .rst_i   (rst_i),
        .flush_i (redirect_o),
        .d_i     (fetch_in),
        .q_o     (fetch_q)
    );

    inst_decoder u_decoder (
        .fetch_i    (fetch_q),
        .rs1_val_i  (rs1_val),
        .rs2_val_i  (rs2_val),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .pkt_o      (dec_pkt)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .rst_i      (rst_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_val_o  (rs1_val),
        .rs2_val_o  (rs2_val),
        .wb_i       (result_o)          // write-back straight from execute
    );

    stage_reg #(
        .payload_t (id_ex_pkt_t),
        .RESET_VAL ('0)
    ) u_id_ex (
        .clk     (clk),
        .rst_i   (rst_i),
        .flush_i (redirect_o),
        .d_i     (dec_pkt),
        .q_o     (ex_pkt)
    );

    exec_unit u_exec (
        .pkt_i      (ex_pkt),
        .result_o   (result_o),
        .redirect_o (redirect_o),
        .target_o   (target_o)
    );

endmodule

// ==== verification/tb_id_ex_core.sv ====
module tb_id_ex_core import core_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 20;
    localparam int N_IDLE     = 30;
    localparam int N_UPPER    = 40;
    localparam int N_ALU      = 300;
    localparam int N_DEP      = 64;
    localparam int N_BRANCH   = 96;      // three slots each
    localparam int N_JUMP     = 40;      // three slots each
    localparam int NUM_SLOTS  = N_IDLE + N_UPPER + N_ALU + N_DEP + 3 * (N_BRANCH + N_JUMP) + 4;

    typedef struct packed {
        ex_result_t res;
        logic       redirect;
        xlen_t      target;
    } expect_t;

    logic        clk = 1'b0;
    logic        rst_i;
    logic        valid_i;
    xlen_t       pc_i;
    logic [31:0] instr_i;
    ex_result_t  result;
    logic        redirect;
    xlen_t       target;

    integer  seed = 32'he131_09df;
    xlen_t   arch_regs [32];
    int      skip_left;
    xlen_t   next_pc;
    expect_t exp_q [$];

    always #(CLK_PERIOD / 2) clk = ~clk;

    id_ex_core UUT (
        .clk        (clk),
        .rst_i      (rst_i),
        .valid_i    (valid_i),
        .pc_i       (pc_i),
        .instr_i    (instr_i),
        .result_o   (result),
        .redirect_o (redirect),
        .target_o   (target)
    );

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic reg_addr_t rand_reg(input logic nonzero);
        logic [31:0] r;
        r = rand32();
        if (nonzero && r[4:0] == 5'd0) r[0] = 1'b1;
        return r[4:0];
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                          input reg_addr_t rs1, input logic [2:0] f3,
                                          input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                          input logic [2:0] f3, input reg_addr_t rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input reg_addr_t rs2,
                                          input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // random op or op-imm with legally encoded shifts
    function automatic logic [31:0] rand_alu(input reg_addr_t rd, input reg_addr_t rs1,
                                             input reg_addr_t rs2);
        logic [31:0] r;
        logic [2:0]  f3;
        logic        alt;
        logic [31:0] ins;
        r   = rand32();
        f3  = r[2:0];
        alt = r[3] && (f3 == 3'b000 || f3 == 3'b101);
        if (r[4]) begin
            ins = enc_r({1'b0, alt, 5'b0}, rs2, rs1, f3, rd);
        end else if (f3 == 3'b001 || f3 == 3'b101) begin
            ins = enc_i({1'b0, alt, 4'b0, r[13:8]}, rs1, f3, rd, 7'b0010011);
        end else begin
            ins = enc_i(r[31:20], rs1, f3, rd, 7'b0010011);
        end
        return ins;
    endfunction

    function automatic xlen_t alu_ref(input logic [2:0] f3, input logic alt, input xlen_t a,
                                      input xlen_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[5:0];
            3'b010:  return {63'b0, $signed(a) < $signed(b)};
            3'b011:  return {63'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? $unsigned($signed(a) >>> b[5:0]) : a >> b[5:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // architectural model called once per input slot in issue order
    function automatic expect_t predict(input logic v, input xlen_t pc, input logic [31:0] ins);
        expect_t    e;
        reg_addr_t  rd;
        logic [2:0] f3;
        xlen_t      a;
        xlen_t      b;
        xlen_t      imm_i;
        xlen_t      val;
        logic       ok;
        logic       wr;
        e     = '0;
        rd    = ins[11:7];
        f3    = ins[14:12];
        a     = arch_regs[ins[19:15]];
        b     = arch_regs[ins[24:20]];
        imm_i = {{52{ins[31]}}, ins[31:20]};
        val   = '0;
        ok    = v;
        wr    = 1'b1;
        if (skip_left > 0) begin
            skip_left--;                                     // flushed behind a redirect
            ok = 1'b0;
        end
        case (ins[6:0])
            7'b0110011: begin
                ok &= ins[31:25] == 7'h00 ||
                      (ins[31:25] == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
                val = alu_ref(f3, ins[30], a, b);
            end
            7'b0010011: begin
                if (f3 == 3'b001) ok &= ins[31:26] == 6'b000000;
                if (f3 == 3'b101) ok &= ins[31:26] == 6'b000000 || ins[31:26] == 6'b010000;
                val = alu_ref(f3, f3 == 3'b101 && ins[30], a, imm_i);
            end
            7'b0110111: val = {{32{ins[31]}}, ins[31:12], 12'b0};
            7'b0010111: val = pc + {{32{ins[31]}}, ins[31:12], 12'b0};
            7'b1101111: begin
                val        = pc + 64'd4;
                e.redirect = 1'b1;
                e.target   = pc + {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            7'b1100111: begin
                ok        &= f3 == 3'b000;
                val        = pc + 64'd4;
                e.redirect = 1'b1;
                e.target   = (a + imm_i) & ~64'd1;
            end
            7'b1100011: begin
                wr  = 1'b0;
                ok &= f3 != 3'b010 && f3 != 3'b011;
                case (f3)
                    3'b000:  e.redirect = a == b;
                    3'b001:  e.redirect = a != b;
                    3'b100:  e.redirect = $signed(a) < $signed(b);
                    3'b101:  e.redirect = $signed(a) >= $signed(b);
                    3'b110:  e.redirect = a < b;
                    default: e.redirect = a >= b;
                endcase
                e.target = pc + {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            default: ok = 1'b0;
        endcase
        if (!ok) return '0;
        e.res = '{valid: 1'b1, rd: rd, wen: wr && rd != 5'd0, value: val};
        if (e.res.wen) arch_regs[rd] = val;
        if (e.redirect) skip_left = 2;                       // the two younger slots
        return e;
    endfunction

    task automatic report_failure(input string msg);
        $display("FAILED at %0d ns: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic check_result(input ex_result_t exp, input ex_result_t act);
        if (act.valid !== exp.valid || act.wen !== exp.wen) begin
            report_failure($sformatf("result valid %b wen %b, expected valid %b wen %b",
                                     act.valid, act.wen, exp.valid, exp.wen));
        end else if (exp.wen && (act.rd !== exp.rd || act.value !== exp.value)) begin
            report_failure($sformatf("x%0d = %h, expected x%0d = %h",
                                     act.rd, act.value, exp.rd, exp.value));
        end
    endtask

    task automatic check_redirect(input logic exp_redir, input xlen_t exp_tgt,
                                  input logic act_redir, input xlen_t act_tgt);
        if (act_redir !== exp_redir) begin
            report_failure($sformatf("redirect %b, expected %b", act_redir, exp_redir));
        end else if (exp_redir && act_tgt !== exp_tgt) begin
            report_failure($sformatf("target %h, expected %h", act_tgt, exp_tgt));
        end
    endtask

    task automatic issue(input logic v, input logic [31:0] ins);
        @(posedge clk);
        valid_i <= v;
        pc_i    <= next_pc;
        instr_i <= ins;
        exp_q.push_back(predict(v, next_pc, ins));
        next_pc = next_pc + 64'd4;
    endtask

    initial begin
        logic [31:0] r;
        logic [2:0]  f3;
        reg_addr_t   prev;
        reg_addr_t   rd;
        rst_i     = 1'b1;
        valid_i   = 1'b0;
        pc_i      = '0;
        instr_i   = '0;
        next_pc   = 64'h0000_0000_8000_0000;
        skip_left = 0;
        for (int i = 0; i < 32; i++) begin
            arch_regs[i] = '0;
        end
        repeat (8) @(posedge clk);
        rst_i <= 1'b0;

        for (int i = 0; i < N_IDLE; i++) begin             // idle, unknown opcodes, mul
            r = rand32();
            case (i % 3)
                0:       issue(1'b0, r);
                1:       issue(1'b1, {r[31:7], r[0] ? 7'b0000011 : 7'b1110011});
                default: issue(1'b1, enc_r(7'b0000001, rand_reg(1'b0), rand_reg(1'b0),
                                           r[2:0], rand_reg(1'b1)));
            endcase
        end
        for (int i = 0; i < N_UPPER; i++) begin
            r = rand32();
            issue(1'b1, {r[31:12], rand_reg(1'b1), i[0] ? 7'b0010111 : 7'b0110111});
        end
        for (int i = 0; i < N_ALU; i++) begin
            issue(1'b1, rand_alu(rand_reg(1'b0), rand_reg(1'b0), rand_reg(1'b0)));
        end

        prev = 5'd1;
        for (int i = 0; i < N_DEP; i++) begin              // each op reads the one before
            r  = rand32();
            rd = rand_reg(1'b1);
            if (i % 8 == 6) begin
                issue(1'b1, enc_i(r[11:0], prev, 3'b000, 5'd0, 7'b0010011));
            end else if (i % 8 == 7) begin
                issue(1'b1, enc_r(7'b0, prev, 5'd0, 3'b000, rd));    // x0 must read zero
                prev = rd;
            end else begin
                issue(1'b1, rand_alu(rd, prev, r[31] ? prev : rand_reg(1'b0)));
                prev = rd;
            end
        end

        for (int i = 0; i < N_BRANCH; i++) begin
            r  = rand32();
            f3 = 3'(i % 6);
            if (f3 >= 3'd2) f3 = f3 + 3'd2;
            rd = rand_reg(1'b0);
            issue(1'b1, enc_b({r[31:20], 1'b0}, r[8] ? rd : rand_reg(1'b0), rd, f3));
            repeat (2) issue(1'b1, rand_alu(rand_reg(1'b0), rand_reg(1'b0), rand_reg(1'b0)));
        end
        for (int i = 0; i < N_JUMP; i++) begin
            r = rand32();
            if (i[0]) begin
                issue(1'b1, enc_i(r[11:0], rand_reg(1'b0), 3'b000, rand_reg(1'b0), 7'b1100111));
            end else begin
                issue(1'b1, enc_j({r[31:12], 1'b0}, rand_reg(1'b0)));
            end
            repeat (2) issue(1'b1, rand_alu(rand_reg(1'b0), rand_reg(1'b0), rand_reg(1'b0)));
        end

        repeat (4) issue(1'b0, 32'h0);                       // drain the pipeline
        repeat (4) @(posedge clk);
        $display("Simulation passed");
        $finish;
    end

    // a slot shows up in execute two edges after it is driven
    initial begin
        expect_t e;
        @(posedge clk);
        forever begin
            @(negedge clk);
            if (exp_q.size() >= 3) begin
                e = exp_q.pop_front();
            end else begin
                e = '0;
            end
            check_result(e.res, result);
            check_redirect(e.redirect, e.target, redirect, target);
        end
    end

    initial begin
        #(CLK_PERIOD * (NUM_SLOTS + 50));
        $display("Timeout: the test did not finish within %0d clock cycles", NUM_SLOTS + 50);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== id_ex_core.f ====
source/core_pkg.sv
source/stage_reg.sv
source/inst_decoder.sv
source/reg_file.sv
source/exec_unit.sv
source/id_ex_core.sv
verification/tb_id_ex_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_id_ex_core -f id_ex_core.f -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "testbench reported an error, see sim.log"
    exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
    echo "testbench ended without a verdict, see sim.log"
    exit 1
fi
